//--- verilog/instDecodeStage_defs.svh
`ifndef INST_DECODE_STAGE_DEFS_SVH
`define INST_DECODE_STAGE_DEFS_SVH

// datapath widths
`define INST_W 32
`define ADDR_W 40
`define DATA_W 64
`define REG_W 5
`define FUNC_W 4

// special register numbers
`define REG_BJS 5'd25  // branch/jump status
`define REG_SP 5'd26   // stack pointer
`define REG_NONE 5'd31 // no register, operand comes from the immediate

// instruction class, bits 31:29
`define CLS_IOSTACK 3'd1 // memory io and push/pop
`define CLS_STACKRW 3'd2
`define CLS_BASEOP 3'd3
`define CLS_EXPOP 3'd4   // float ops
`define CLS_MOVINIT 3'd5
// codes 0, 6 and 7 are not decoded

`endif

//--- verilog/decodePkg.sv
`include "instDecodeStage_defs.svh"

package decodePkg;

    typedef logic [`REG_W-1:0] regNum_t;

    typedef enum logic [3:0] {
        MEM_IO,
        STACK_PUSHPOP,
        ALU_ADDSUB,
        ALU_MUL,
        ALU_DIV,
        ALU_BOOL,
        ALU_BIT,
        ALU_EQUAL,
        ALU_CMP_U,
        ALU_CMP_I,
        MOV_INIT,
        FPU_ADDSUB,
        FPU_MUL,
        FPU_DIV,
        FPU_CMP,
        FPU_TRANS
    } opUnit_e;

    // base arithmetic subtypes, all 32 codes used
    typedef enum logic [4:0] {
        ADD, SUB, MUL, UDIV, IDIV, UREM, IREM,
        BAND, BOR, BNOT,
        AND, OR, NOT, XOR, SAL, USOR, ISOR,
        EC, NEC,
        ULC, ULEC, UMC, UMEC,
        ILC, ILEC, IMC, IMEC,
        LDI8, LDU16, LDI16, LDU32, LDI32
    } baseOp_e;

    // extended subtypes, 11..31 unassigned
    typedef enum logic [4:0] {
        FADD, FSUB, FMUL, FDIV,
        FLC, FLEC, FMEC, FMC,
        FTI, ITF, UTF
    } expOp_e;

    typedef struct packed {
        logic                isValid;
        logic                isBranchJump;
        logic [`ADDR_W-1:0]  orderAddress;
        logic [`INST_W-1:0]  orderCode;
    } primaryInfo_t;

    typedef struct packed {
        logic                isValid;
        opUnit_e             opUnit;
        logic [`FUNC_W-1:0]  funcSel;
        regNum_t             operA;
        regNum_t             operB;
        regNum_t             resA;
        regNum_t             resB;
        logic [`DATA_W-1:0]  operImme;
    } operationInfo_t;

    // instruction word views, one per class
    typedef struct packed {
        logic [2:0]  cls;
        logic        isStack;  // 0 for memory io
        logic [3:0]  func;     // func[3] set means store
        regNum_t     dataReg;
        regNum_t     addrReg;
        logic [13:0] imm;
    } memFmt_t;

    typedef struct packed {
        logic [2:0]  cls;
        logic        isStack;
        logic [3:0]  func;
        regNum_t     dataReg;
        logic [18:0] imm;
    } stackFmt_t;

    // function select shares bit 24 with dataReg here
    typedef struct packed {
        logic [2:0]  cls;
        logic        isWrite;
        logic [2:0]  funcHi;
        regNum_t     dataReg;
        logic [19:0] imm;
    } stackRwFmt_t;

    typedef struct packed {
        logic [2:0]  cls;
        logic [4:0]  subType;
        regNum_t     resA;
        regNum_t     operA;
        regNum_t     operB;
        logic [8:0]  imm;
    } arithFmt_t;

    typedef struct packed {
        logic [2:0]  cls;
        logic        isInit;
        regNum_t     dst;
        regNum_t     src;
        logic [17:0] imm;
    } movFmt_t;

    typedef union packed {
        memFmt_t     mem;
        stackFmt_t   stack;
        stackRwFmt_t stackRw;
        arithFmt_t   arith;
        movFmt_t     mov;
    } instWord_u;

    localparam primaryInfo_t invalidPrimary = '{
        isValid: 1'b0,
        isBranchJump: 1'b0,
        orderAddress: '0,
        orderCode: '0
    };

    localparam operationInfo_t invalidOperation = '{
        isValid: 1'b0,
        opUnit: MEM_IO,
        funcSel: '0,
        operA: `REG_NONE,
        operB: `REG_NONE,
        resA: `REG_NONE,
        resB: `REG_NONE,
        operImme: '0
    };

endpackage

//--- verilog/arithOpDecoder.sv
`timescale 1ns/1ps
`include "instDecodeStage_defs.svh"

module arithOpDecoder (
    input  logic                isExtended,
    input  logic [4:0]          subType,
    output decodePkg::opUnit_e  opUnit,
    output logic [`FUNC_W-1:0]  funcSel,
    output logic                known
);
    import decodePkg::*;

    baseOp_e baseSub;
    expOp_e  expSub;

    assign baseSub = baseOp_e'(subType);
    assign expSub = expOp_e'(subType);

    always_comb begin
        opUnit = MEM_IO;
        funcSel = '0;
        known = 1'b1;
        if (isExtended) begin
            case (expSub)
                FADD, FSUB:           opUnit = FPU_ADDSUB;
                FMUL:                 opUnit = FPU_MUL;
                FDIV:                 opUnit = FPU_DIV;
                FLC, FLEC, FMEC, FMC: opUnit = FPU_CMP;
                FTI, ITF, UTF:        opUnit = FPU_TRANS;
                default:              known = 1'b0;
            endcase
            case (expSub)
                FSUB, FMC, FTI: funcSel = 4'd1;
                FLC, ITF:       funcSel = 4'd2;
                FLEC, UTF:      funcSel = 4'd3;
                default:        funcSel = 4'd0;
            endcase
        end else begin
            case (baseSub)
                ADD, SUB:                             opUnit = ALU_ADDSUB;
                MUL:                                  opUnit = ALU_MUL;
                UDIV, IDIV, UREM, IREM:               opUnit = ALU_DIV;
                BAND, BOR, BNOT:                      opUnit = ALU_BOOL;
                AND, OR, NOT, XOR, SAL, USOR, ISOR:   opUnit = ALU_BIT;
                EC, NEC:                              opUnit = ALU_EQUAL;
                ULC, ULEC, UMC, UMEC:                 opUnit = ALU_CMP_U;
                ILC, ILEC, IMC, IMEC:                 opUnit = ALU_CMP_I;
                default:                              opUnit = MOV_INIT; // LDxx
            endcase
            // compare units use 0/1 for greater, 2/3 for less
            case (baseSub)
                SUB, IDIV, BAND, AND, NEC, UMEC, IMEC, LDI8: funcSel = 4'd1;
                UREM, BOR, OR, ULC, ILC, LDU16:              funcSel = 4'd2;
                IREM, BNOT, NOT, ULEC, ILEC, LDI16:          funcSel = 4'd3;
                XOR, LDU32:                                  funcSel = 4'd4;
                SAL, LDI32:                                  funcSel = 4'd5;
                USOR:                                        funcSel = 4'd6;
                ISOR:                                        funcSel = 4'd7;
                default:                                     funcSel = 4'd0;
            endcase
        end
    end

endmodule

//--- verilog/operandDecoder.sv
`timescale 1ns/1ps
`include "instDecodeStage_defs.svh"

module operandDecoder (
    input  decodePkg::primaryInfo_t   fetchInfo,
    output decodePkg::operationInfo_t decodedOp,
    output logic                      illegal
);
    import decodePkg::*;

    instWord_u          word;
    logic [2:0]         cls;
    opUnit_e            arithUnit;
    logic [`FUNC_W-1:0] arithFunc;
    logic               arithKnown;
    logic               recordOk;

    assign word = fetchInfo.orderCode;
    assign cls = word.arith.cls;

    arithOpDecoder arithOpDecoder_inst (
        .isExtended (cls == `CLS_EXPOP),
        .subType    (word.arith.subType),
        .opUnit     (arithUnit),
        .funcSel    (arithFunc),
        .known      (arithKnown)
    );

    // register fields start at REG_NONE, each format fills in what it uses
    always_comb begin
        decodedOp = invalidOperation;
        recordOk = 1'b1;
        case (cls)
            `CLS_IOSTACK: begin
                decodedOp.funcSel = word.mem.func;
                if (!word.mem.isStack) begin
                    decodedOp.opUnit = MEM_IO;
                    decodedOp.operA = word.mem.addrReg;
                    decodedOp.operImme = 64'(signed'(word.mem.imm));
                end else begin
                    decodedOp.opUnit = STACK_PUSHPOP;
                    decodedOp.operA = `REG_SP;
                    decodedOp.resB = `REG_SP; // push/pop always moves sp
                    decodedOp.operImme = 64'(signed'(word.stack.imm));
                end
                if (word.mem.func[3]) begin
                    decodedOp.operB = word.mem.dataReg; // store / push
                end else begin
                    decodedOp.resA = word.mem.dataReg;
                end
            end
            `CLS_STACKRW: begin
                decodedOp.opUnit = MEM_IO;
                decodedOp.funcSel = word.mem.func; // bits 27:24
                decodedOp.operA = `REG_SP;
                decodedOp.operImme = 64'(word.stackRw.imm);
                if (word.stackRw.isWrite) begin
                    decodedOp.operB = word.stackRw.dataReg;
                end else begin
                    decodedOp.resA = word.stackRw.dataReg;
                end
            end
            `CLS_BASEOP, `CLS_EXPOP: begin
                decodedOp.opUnit = arithUnit;
                decodedOp.funcSel = arithFunc;
                decodedOp.operA = word.arith.operA;
                decodedOp.operB = word.arith.operB;
                decodedOp.resA = word.arith.resA;
                decodedOp.operImme = 64'(signed'(word.arith.imm));
                recordOk = arithKnown;
            end
            `CLS_MOVINIT: begin
                decodedOp.opUnit = MOV_INIT;
                decodedOp.resA = word.mov.dst;
                if (word.mov.isInit) begin
                    decodedOp.funcSel = 4'd6; // init from 23-bit literal
                    decodedOp.operA = word.mov.dst;
                    decodedOp.operImme = 64'({word.mov.src, word.mov.imm});
                end else begin
                    decodedOp.funcSel = 4'd0;
                    decodedOp.operA = word.mov.src;
                    decodedOp.operImme = 64'(signed'(word.mov.imm));
                end
            end
            default: recordOk = 1'b0;
        endcase
        decodedOp.isValid = 1'b1;
        if (!fetchInfo.isValid || !recordOk) begin
            decodedOp = invalidOperation;
        end
    end

    // an empty slot is not an illegal instruction
    assign illegal = fetchInfo.isValid && !recordOk;

endmodule

//--- verilog/branchResolver.sv
`timescale 1ns/1ps
`include "instDecodeStage_defs.svh"

module branchResolver (
    input  logic                      start,
    input  logic                      clean,
    input  decodePkg::primaryInfo_t   fetchInfo,
    input  decodePkg::operationInfo_t execOperation,
    input  logic [`DATA_W-1:0]        bjsValue,
    output logic                      running,
    output logic                      branchResolved,
    output logic                      branchTaken,
    output decodePkg::primaryInfo_t   resolvedPrimary
);

    logic bjsPending; // op in execute still writes R25

    assign running = start && fetchInfo.isValid && !clean;

    assign bjsPending = (execOperation.resA == `REG_BJS) ||
                        (execOperation.resB == `REG_BJS);

    assign branchResolved = running && fetchInfo.isBranchJump && !bjsPending;

    assign branchTaken = (bjsValue == '0);

    // a resolved branch leaves this stage as a plain instruction
    always_comb begin
        resolvedPrimary = fetchInfo;
        if (branchResolved) begin
            resolvedPrimary.isBranchJump = 1'b0;
        end
    end

endmodule

//--- verilog/stageRegister.sv
`timescale 1ns/1ps
`include "instDecodeStage_defs.svh"

module stageRegister (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      clean,
    input  logic                      start,
    input  logic                      nextReady,
    input  decodePkg::primaryInfo_t   nextPrimary,
    input  decodePkg::operationInfo_t nextOperation,
    output decodePkg::primaryInfo_t   execPrimary,
    output decodePkg::operationInfo_t execOperation
);
    import decodePkg::*;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            execPrimary <= invalidPrimary;
            execOperation <= invalidOperation;
        end else if (clean) begin
            execPrimary <= invalidPrimary;
            execOperation <= invalidOperation;
        end else if (start) begin
            execPrimary <= nextPrimary;
            execOperation <= nextOperation;
        end else if (nextReady) begin
            // execute took the record and nothing new arrived
            execPrimary <= invalidPrimary;
            execOperation <= invalidOperation;
        end
    end

    cleanEmpties: assert property (
        @(posedge clk) disable iff (!rst)
        clean |=> !execPrimary.isValid && !execOperation.isValid
    );

    // decoder and branch path must agree on which slot is occupied
    opHasPrimary: assert property (
        @(posedge clk) disable iff (!rst)
        execOperation.isValid |-> execPrimary.isValid
    );

    pushPopMovesSp: assert property (
        @(posedge clk) disable iff (!rst)
        execOperation.opUnit == STACK_PUSHPOP |-> execOperation.resB == `REG_SP
    );

endmodule

//--- verilog/instDecodeStage.sv
`timescale 1ns/1ps
`include "instDecodeStage_defs.svh"

module instDecodeStage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      clean,
    input  logic                      start,
    input  logic                      nextReady,
    input  decodePkg::primaryInfo_t   fetchInfo,
    input  logic [`DATA_W-1:0]        bjsValue,
    output logic                      running,
    output logic                      branchResolved,
    output logic                      branchTaken,
    output decodePkg::primaryInfo_t   execPrimary,
    output decodePkg::operationInfo_t execOperation
);
    import decodePkg::*;

    operationInfo_t decodedOp;
    primaryInfo_t   resolvedPrimary;

    operandDecoder operandDecoder_inst (
        .fetchInfo (fetchInfo),
        .decodedOp (decodedOp),
        .illegal   ()
    );

    branchResolver branchResolver_inst (
        .start           (start),
        .clean           (clean),
        .fetchInfo       (fetchInfo),
        .execOperation   (execOperation), // held op, may still own R25
        .bjsValue        (bjsValue),
        .running         (running),
        .branchResolved  (branchResolved),
        .branchTaken     (branchTaken),
        .resolvedPrimary (resolvedPrimary)
    );

    stageRegister stageRegister_inst (
        .clk           (clk),
        .rst           (rst),
        .clean         (clean),
        .start         (start),
        .nextReady     (nextReady),
        .nextPrimary   (resolvedPrimary),
        .nextOperation (decodedOp),
        .execPrimary   (execPrimary),
        .execOperation (execOperation)
    );

endmodule

//--- verif/decodeChecks.svh
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) failNow($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic checkPrimary(input string name, input primaryInfo_t got, input primaryInfo_t exp);
    if (got !== exp) failNow($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

// empty slot only defines valid flag and register fields
task automatic checkOperation(input string name, input operationInfo_t got,
                              input operationInfo_t exp);
    logic bad;
    bad = exp.isValid ? (got !== exp) : (got.isValid !== 1'b0 || got.operA !== exp.operA ||
          got.operB !== exp.operB || got.resA !== exp.resA || got.resB !== exp.resB);
    if (bad) failNow($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

function automatic operationInfo_t noneOp();
    operationInfo_t e;
    e = '0;
    e.operA = `REG_NONE;
    e.operB = `REG_NONE;
    e.resA = `REG_NONE;
    e.resB = `REG_NONE;
    return e;
endfunction

// subtype tables
function automatic void arithEntry(input logic ext, input logic [4:0] s,
                                   output opUnit_e u, output logic [3:0] f, output logic k);
    k = 1'b1;
    u = MEM_IO;
    f = 4'd0;
    if (ext) begin
        if (s <= 1) u = FPU_ADDSUB;
        else if (s == 2) u = FPU_MUL;
        else if (s == 3) u = FPU_DIV;
        else if (s <= 7) u = FPU_CMP;
        else if (s <= 10) u = FPU_TRANS;
        else k = 1'b0;
        if (s <= 1) f = 4'(s);
        else if (s <= 3) f = 4'd0;
        else if (s <= 7) f = {2'b0, s[1:0] + 2'd2}; // FLC at 4
        else if (s <= 10) f = 4'(s - 7);
    end else begin
        if (s <= 1) u = ALU_ADDSUB;
        else if (s == 2) u = ALU_MUL;
        else if (s <= 6) u = ALU_DIV;
        else if (s <= 9) u = ALU_BOOL;
        else if (s <= 16) u = ALU_BIT;
        else if (s <= 18) u = ALU_EQUAL;
        else if (s <= 22) u = ALU_CMP_U;
        else if (s <= 26) u = ALU_CMP_I;
        else u = MOV_INIT;
        if (s <= 1) f = 4'(s);
        else if (s == 2) f = 4'd0;
        else if (s <= 6) f = 4'(s - 3);
        else if (s <= 9) f = 4'(s - 6);
        else if (s <= 16) f = 4'(s - 9);
        else if (s <= 18) f = 4'(s - 17);
        else if (s <= 26) f = {2'b0, s[1:0] - 2'd1}; // ULC and ILC sit at 3 mod 4
        else f = 4'(s - 26);
    end
endfunction

function automatic operationInfo_t expectOp(input primaryInfo_t p);
    operationInfo_t e;
    logic [31:0] w;
    opUnit_e u;
    logic [3:0] f;
    logic k;
    w = p.orderCode;
    e = noneOp();
    k = p.isValid;
    e.funcSel = w[27:24];
    case (w[31:29])
        3'd1: begin
            e.opUnit = w[28] ? STACK_PUSHPOP : MEM_IO;
            e.operA = w[28] ? `REG_SP : w[18:14];
            e.resB = w[28] ? `REG_SP : `REG_NONE;
            e.operImme = w[28] ? {{45{w[18]}}, w[18:0]} : {{50{w[13]}}, w[13:0]};
            if (w[27]) e.operB = w[23:19];
            else e.resA = w[23:19];
        end
        3'd2: begin
            e.opUnit = MEM_IO;
            e.operA = `REG_SP;
            e.operImme = {44'b0, w[19:0]};
            if (w[28]) e.operB = w[24:20];
            else e.resA = w[24:20];
        end
        3'd3, 3'd4: begin
            arithEntry(w[31:29] == 3'd4, w[28:24], u, f, k);
            k = k && p.isValid;
            e.opUnit = u;
            e.funcSel = f;
            e.operA = w[18:14];
            e.operB = w[13:9];
            e.resA = w[23:19];
            e.operImme = {{55{w[8]}}, w[8:0]};
        end
        3'd5: begin
            e.opUnit = MOV_INIT;
            e.resA = w[27:23];
            e.funcSel = w[28] ? 4'd6 : 4'd0;
            e.operA = w[28] ? w[27:23] : w[22:18];
            e.operImme = w[28] ? {41'b0, w[22:0]} : {{46{w[17]}}, w[17:0]};
        end
        default: k = 1'b0;
    endcase
    if (!k) return noneOp();
    e.isValid = 1'b1;
    return e;
endfunction

`endif

//--- verif/instDecodeStage_tb.sv
`timescale 1ns/1ps
`include "instDecodeStage_defs.svh"

module instDecodeStage_tb;
    import decodePkg::*;

    logic clk, rst, clean, start, nextReady;
    logic [63:0] bjsValue;
    logic running, branchResolved, branchTaken;
    logic sawRunning, sawResolved, sawTaken;
    primaryInfo_t fetchInfo, execPrimary;
    operationInfo_t execOperation;
    logic [31:0] lfsrState = 32'hd37f;

    instDecodeStage instDecodeStage_inst (.*);

    always #50 clk = ~clk;

    task automatic failNow(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    `include "decodeChecks.svh"

    function automatic logic [63:0] randBits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h80200003 : lfsrState >> 1;
            v = {v[62:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic primaryInfo_t makeFetch(input logic [31:0] w, input logic isBr);
        return '{isValid: 1'b1, isBranchJump: isBr, orderAddress: 40'(randBits(40)),
                 orderCode: w};
    endfunction

    // one start cycle, comb outputs sampled mid-cycle, then wait for the record
    task automatic applyFetch(input primaryInfo_t p, input logic c, input logic n,
                              input logic expectLoad);
        int k;
        @(posedge clk);
        fetchInfo <= p;
        start <= 1'b1;
        clean <= c;
        nextReady <= n;
        @(negedge clk);
        sawRunning = running;
        sawResolved = branchResolved;
        sawTaken = branchTaken;
        @(posedge clk);
        start <= 1'b0;
        clean <= 1'b0;
        nextReady <= 1'b0;
        for (k = 0; k < 4; k++) begin
            @(negedge clk);
            if ((execPrimary.isValid && execPrimary.orderAddress == p.orderAddress) == expectLoad)
                break;
        end
        if (k != 0) failNow("stage did not take the record one cycle after start");
    endtask

    task automatic loadAndCheck(input logic [31:0] w);
        primaryInfo_t p;
        p = makeFetch(w, 1'b0);
        applyFetch(p, 1'b0, 1'b0, 1'b1);
        checkPrimary("execPrimary", execPrimary, p);
        checkOperation("execOperation", execOperation, expectOp(p));
    endtask

    task automatic testReset();
        @(negedge clk);
        checkBit("running", running, 1'b0);
        checkBit("branchResolved", branchResolved, 1'b0);
        checkBit("execPrimary.isValid", execPrimary.isValid, 1'b0);
        checkBit("execPrimary.isBranchJump", execPrimary.isBranchJump, 1'b0);
        checkOperation("execOperation", execOperation, noneOp());
    endtask

    task automatic testFormats();
        for (int i = 0; i < 8; i++) begin
            loadAndCheck({3'd1, 1'b0, i[0], 27'(randBits(27))}); // io
            loadAndCheck({3'd1, 1'b1, i[0], 27'(randBits(27))}); // push/pop
            loadAndCheck({3'd2, i[0], 28'(randBits(28))});
            loadAndCheck({3'd5, i[0], 28'(randBits(28))});
        end
    endtask

    task automatic testArith();
        for (int s = 0; s < 32; s++) begin
            loadAndCheck({3'd3, 5'(s), 24'(randBits(24))});
            loadAndCheck({3'd4, 5'(s), 24'(randBits(24))}); // 11+ invalid
        end
        loadAndCheck({3'd0, 29'(randBits(29))});
        loadAndCheck({3'd6, 29'(randBits(29))});
        loadAndCheck({3'd7, 29'(randBits(29))});
    endtask

    task automatic testBranch();
        primaryInfo_t p;
        loadAndCheck({3'd3, 5'd0, 5'd25, 19'(randBits(19))}); // ADD into R25
        @(posedge clk);
        bjsValue <= 64'd0;
        p = makeFetch({3'd5, 1'b0, 5'd3, 23'(randBits(23))}, 1'b1);
        applyFetch(p, 1'b0, 1'b0, 1'b1);
        checkBit("branchResolved", sawResolved, 1'b0);
        checkBit("branchTaken", sawTaken, 1'b1);
        checkPrimary("execPrimary", execPrimary, p);
        @(posedge clk);
        bjsValue <= randBits(63) + 64'd1;
        p = makeFetch({3'd5, 1'b0, 5'd4, 23'(randBits(23))}, 1'b1);
        applyFetch(p, 1'b0, 1'b0, 1'b1);
        checkBit("running", sawRunning, 1'b1);
        checkBit("branchResolved", sawResolved, 1'b1);
        checkBit("branchTaken", sawTaken, 1'b0);
        p.isBranchJump = 1'b0;
        checkPrimary("execPrimary", execPrimary, p);
    endtask

    task automatic testControl();
        primaryInfo_t p;
        loadAndCheck({3'd2, 29'(randBits(29))});
        @(posedge clk);
        nextReady <= 1'b1;
        @(posedge clk);
        nextReady <= 1'b0;
        @(negedge clk);
        checkBit("execPrimary.isValid", execPrimary.isValid, 1'b0);
        checkOperation("execOperation", execOperation, noneOp());
        p = makeFetch({3'd1, 29'(randBits(29))}, 1'b0);
        applyFetch(p, 1'b1, 1'b0, 1'b0); // clean wins over start
        checkBit("running", sawRunning, 1'b0);
        checkBit("execPrimary.isValid", execPrimary.isValid, 1'b0);
        checkOperation("execOperation", execOperation, noneOp());
        p = makeFetch({3'd5, 29'(randBits(29))}, 1'b0);
        applyFetch(p, 1'b0, 1'b1, 1'b1);
        checkPrimary("execPrimary", execPrimary, p);
        checkOperation("execOperation", execOperation, expectOp(p));
    endtask

    initial begin
        #2_000_000;
        failNow("simulation hung, watchdog expired");
    end

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        clean = 1'b0;
        start = 1'b0;
        nextReady = 1'b0;
        fetchInfo = '0;
        bjsValue = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        testReset();
        testFormats();
        testArith();
        testBranch();
        testControl();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- instDecodeStage.f
+incdir+verilog
+incdir+verif
verilog/decodePkg.sv
verilog/arithOpDecoder.sv
verilog/operandDecoder.sv
verilog/branchResolver.sv
verilog/stageRegister.sv
verilog/instDecodeStage.sv
verif/instDecodeStage_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary -j 0 --assert -Wall
TOP       ?= instDecodeStage_tb
FILELIST  ?= instDecodeStage.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
